// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mxint_exp_front_tb \
		-f files.f -Mdir obj_dir
	@out="$$(./obj_dir/Vmxint_exp_front_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: files.f
verilog/mxint_exp_pkg.sv
verilog/stream_fork.sv
verilog/mxint_log2e_round.sv
verilog/range_residual.sv
verilog/mxint_range_reduction.sv
verilog/exp_residual_poly.sv
verilog/mxint_exp_front.sv
verif/mxint_exp_front_sva.sv
verif/mxint_exp_front_tb.sv

// File: verif/mxint_exp_front_sva.sv
`timescale 1ns/100ps

module mxint_exp_front_sva
    import mxint_exp_pkg::*;
#(
    parameter int BLOCK_SIZE = 4
) (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       in_ready,
    input exp_elem_t [BLOCK_SIZE-1:0] out_elem,
    input logic                       out_valid,
    input logic                       out_ready
);

    a_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({out_valid, in_ready}))
        else $error("out_valid or in_ready is unknown after reset");

    // A stalled output block stays offered and unchanged until it is taken
    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_elem))
        else $error("output block changed or dropped while stalled");

    a_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid is high while arst_n is low");

endmodule

// File: verif/mxint_exp_front_tb.sv
`timescale 1ns/100ps

module mxint_exp_front_tb
    import mxint_exp_pkg::*;
();
    localparam int BLOCK_SIZE    = 4;
    localparam int CLK_PERIOD    = 20;
    localparam int RANDOM_BLOCKS = 200;
    localparam int STREAM_BLOCKS = 100;
    // Directed, random, latency, back-pressure and streaming blocks
    localparam int PLANNED_BLOCKS = 5 + RANDOM_BLOCKS + 1 + RANDOM_BLOCKS + STREAM_BLOCKS;
    localparam int LOG2E_Q6 = 92;
    localparam int LN2_Q7   = 88;

    typedef logic [BLOCK_SIZE-1:0][MAN_WIDTH-1:0] mant_blk_t;
    typedef exp_elem_t [BLOCK_SIZE-1:0] out_blk_t;

    logic                 clk;
    logic                 arst_n;
    mant_blk_t            in_mant;
    logic [EXP_WIDTH-1:0] in_exp;
    logic                 in_valid;
    logic                 in_ready;
    out_blk_t             out_elem;
    logic                 out_valid;
    logic                 out_ready;

    integer   seed;
    integer   ready_rand;
    logic     next_ready;
    logic     bp_mode;
    logic     stalled = 1'b0;
    out_blk_t held_elem;
    out_blk_t exp_q[$];
    int       cycle = 0;
    int       in_count = 0;
    int       out_count = 0;
    int       last_out_cycle = 0;
    int       xfer_cycle = 0;
    int       error_count = 0;
    int       test_errors = 0;
    int       tests_run = 0;

    mxint_exp_front #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_mxint_exp_front (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_mant   (in_mant),
        .in_exp    (in_exp),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_elem  (out_elem),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    bind mxint_exp_front mxint_exp_front_sva #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_sva (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_ready  (in_ready),
        .out_elem  (out_elem),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Ready for the next rising edge is drawn at the falling edge
    always @(negedge clk) begin
        if (bp_mode) begin
            ready_rand = $random(seed);
            next_ready = ready_rand[0];
        end else begin
            next_ready = 1'b1;
        end
    end

    always @(posedge clk) out_ready <= next_ready;

    // floor(v * 2^sh) with one half added before the floor when rounding
    function automatic longint scale(input longint v, input int sh, input bit round_half);
        int s;
        if (v == 0) return 0;
        if (sh > 40) return (v > 0) ? (longint'(1) <<< 40) : -(longint'(1) <<< 40);
        if (sh >= 0) return v <<< sh;
        s = (-sh > 40) ? 40 : -sh;
        if (round_half) return (v + (longint'(1) <<< (s - 1))) >>> s;
        return v >>> s;
    endfunction

    function automatic longint clamp(input longint v, input longint lo, input longint hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    function automatic out_blk_t model_block(input mant_blk_t mant,
                                             input logic [EXP_WIDTH-1:0] e_bits);
        out_blk_t res;
        longint   m;
        longint   n;
        longint   a;
        longint   r;
        int       e;
        e = int'($signed(e_bits));
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            m = longint'($signed(mant[i]));
            n = clamp(scale(m * LOG2E_Q6, e - 9, 1'b1), -128, 127);
            a = clamp(scale(m, e + 4, 1'b0), -32768, 32767);
            r = clamp(a - n * LN2_Q7, -256, 255);
            res[i].n    = N_WIDTH'(n);
            res[i].mant = EXPM_WIDTH'(128 + r + (r * r) / 256);
        end
        return res;
    endfunction

    function automatic mant_blk_t pack_lanes(input int m0, input int m1,
                                             input int m2, input int m3);
        mant_blk_t b;
        b[0] = MAN_WIDTH'(m0);
        b[1] = MAN_WIDTH'(m1);
        b[2] = MAN_WIDTH'(m2);
        b[3] = MAN_WIDTH'(m3);
        return b;
    endfunction

    task automatic compare_block(input out_blk_t exp_blk, input out_blk_t got);
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            if (got[i].n !== exp_blk[i].n) begin
                $display("Fail out_elem[%0d].n: expected %h, got %h", i, exp_blk[i].n, got[i].n);
                error_count++;
            end
            if (got[i].mant !== exp_blk[i].mant) begin
                $display("Fail out_elem[%0d].mant: expected %h, got %h", i,
                         exp_blk[i].mant, got[i].mant);
                error_count++;
            end
        end
    endtask

    // Called on a rising edge, returns on the edge where the block transfers
    task automatic drive_block(input mant_blk_t mant, input logic [EXP_WIDTH-1:0] e_bits);
        in_mant  <= mant;
        in_exp   <= e_bits;
        in_valid <= 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        xfer_cycle = cycle;
        in_valid <= 1'b0;
    endtask

    task automatic send_random_block();
        integer r;
        r = $random(seed);
        // Mostly exponents near zero, now and then one from the full range
        drive_block(r[31:16], (r[7:5] == 3'd0) ? r[15:8] : EXP_WIDTH'(int'(r[11:8]) - 6));
    endtask

    task automatic wait_drain();
        @(posedge clk);
        while (out_count != in_count) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished with %0d errors", name, error_count - test_errors);
        test_errors = error_count;
        tests_run++;
    endtask

    // Scoreboard with the stall hold check
    always @(posedge clk) begin
        if (arst_n) begin
            if (stalled && !out_valid) begin
                $display("out_valid dropped while the output was stalled");
                error_count++;
            end else if (stalled && out_elem !== held_elem) begin
                $display("Fail out_elem: held %h, changed to %h", held_elem, out_elem);
                error_count++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("An output block arrived with no input block pending");
                    error_count++;
                end else begin
                    compare_block(exp_q.pop_front(), out_elem);
                end
                out_count      <= out_count + 1;
                last_out_cycle <= cycle;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(model_block(in_mant, in_exp));
                in_count <= in_count + 1;
            end
            stalled   <= out_valid && !out_ready;
            held_elem <= out_elem;
        end
    end

    initial begin
        #(CLK_PERIOD * (PLANNED_BLOCKS * 40 + 100));
        $display("Timeout: the blocks did not all come out within the cycle budget");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int start;
        int base;
        seed       = 32'ha5d6_6988;
        in_mant    = '0;
        in_exp     = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        next_ready = 1'b1;
        bp_mode    = 1'b0;
        arst_n     = 1'b1;
        #1;
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        if (out_valid !== 1'b0) begin
            $display("Fail out_valid after reset: expected %h, got %h", 1'b0, out_valid);
            error_count++;
        end
        if (in_ready !== 1'b1) begin
            $display("Fail in_ready after reset: expected %h, got %h", 1'b1, in_ready);
            error_count++;
        end
        report_test("reset_state");

        // Zero, plus and minus one, n saturation and the r clamp at both ends
        drive_block(pack_lanes(0, 0, 0, 0), 8'd0);
        drive_block(pack_lanes(4, -4, 2, -2), 8'd1);
        drive_block(pack_lanes(7, -8, 1, -1), 8'd100);
        drive_block(pack_lanes(7, -8, 1, -1), 8'd10);
        drive_block(pack_lanes(7, -8, -1, 1), 8'h80);
        wait_drain();
        report_test("directed_values");

        repeat (RANDOM_BLOCKS) send_random_block();
        wait_drain();
        report_test("random_blocks");

        base = out_count;
        drive_block(pack_lanes(3, -2, 5, -7), 8'd2);
        start = xfer_cycle;
        while (out_count == base) begin
            @(posedge clk);
        end
        if (last_out_cycle - start != 3) begin
            $display("Fail latency cycles: expected %h, got %h", 3, last_out_cycle - start);
            error_count++;
        end
        report_test("latency");

        bp_mode = 1'b1;
        repeat (RANDOM_BLOCKS) begin
            repeat ($random(seed) & 3) @(posedge clk);
            send_random_block();
        end
        bp_mode = 1'b0;
        wait_drain();
        report_test("back_pressure");

        send_random_block();
        start = xfer_cycle;
        repeat (STREAM_BLOCKS - 1) send_random_block();
        if (xfer_cycle - start != STREAM_BLOCKS - 1) begin
            $display("Fail stream transfer cycles: expected %h, got %h",
                     STREAM_BLOCKS - 1, xfer_cycle - start);
            error_count++;
        end
        wait_drain();
        report_test("streaming");

        if (exp_q.size() != 0) begin
            $display("%0d expected blocks never came out", exp_q.size());
            error_count++;
        end
        $display("Tests run: %0d, blocks in: %0d, blocks out: %0d, errors: %0d",
                 tests_run, in_count, out_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog/exp_residual_poly.sv
`timescale 1ns/100ps

module exp_residual_poly
    import mxint_exp_pkg::*;
#(
    parameter int BLOCK_SIZE = 4
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [BLOCK_SIZE-1:0][N_WIDTH-1:0] n_in,
    input  logic                              n_valid,
    output logic                              n_ready,
    input  logic [BLOCK_SIZE-1:0][R_WIDTH-1:0] r_in,
    input  logic                              r_valid,
    output logic                              r_ready,
    output exp_elem_t [BLOCK_SIZE-1:0]         out_elem,
    output logic                              out_valid,
    input  logic                              out_ready
);
    localparam int SQ_WIDTH = 2 * R_WIDTH;
    localparam logic signed [SQ_WIDTH-1:0] ONE = 1 << R_FRAC;

    exp_elem_t [BLOCK_SIZE-1:0] elem_next;
    logic                       out_accept;
    logic                       fire;

    // e^r ~ 1 + r + r^2/2, with r^2 scaled back from 2*R_FRAC fraction bits
    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_lane
        logic signed [SQ_WIDTH-1:0] sq;
        logic signed [SQ_WIDTH-1:0] sum;
        assign sq                = $signed(r_in[i]) * $signed(r_in[i]);
        assign sum               = ONE + $signed(r_in[i]) + (sq >>> (R_FRAC + 1));
        assign elem_next[i].n    = n_in[i];
        assign elem_next[i].mant = sum[EXPM_WIDTH-1:0];
    end

    assign out_accept = !out_valid || out_ready;
    assign fire       = n_valid && r_valid && out_accept;
    assign n_ready    = r_valid && out_accept;
    assign r_ready    = n_valid && out_accept;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_elem <= elem_next;
        end
    end

endmodule

// File: verilog/mxint_exp_front.sv
`timescale 1ns/100ps

module mxint_exp_front
    import mxint_exp_pkg::*;
#(
    parameter int BLOCK_SIZE = 4
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [BLOCK_SIZE-1:0][MAN_WIDTH-1:0] in_mant,
    input  logic [EXP_WIDTH-1:0]                 in_exp,
    input  logic                                in_valid,
    output logic                                in_ready,
    output exp_elem_t [BLOCK_SIZE-1:0]           out_elem,
    output logic                                out_valid,
    input  logic                                out_ready
);
    logic [BLOCK_SIZE-1:0][N_WIDTH-1:0] n;
    logic                               n_valid;
    logic                               n_ready;
    logic [BLOCK_SIZE-1:0][R_WIDTH-1:0] r;
    logic                               r_valid;
    logic                               r_ready;

    // n FIFO is one deeper than the mantissa FIFO to cover the residual stage
    mxint_range_reduction #(
        .BLOCK_SIZE      (BLOCK_SIZE),
        .MANT_FIFO_DEPTH (2),
        .N_FIFO_DEPTH    (3)
    ) u_range_reduction (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_mant  (in_mant),
        .in_exp   (in_exp),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .n_out    (n),
        .n_valid  (n_valid),
        .n_ready  (n_ready),
        .r_out    (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    exp_residual_poly #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_poly (
        .clk       (clk),
        .arst_n    (arst_n),
        .n_in      (n),
        .n_valid   (n_valid),
        .n_ready   (n_ready),
        .r_in      (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .out_elem  (out_elem),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// File: verilog/mxint_exp_pkg.sv
package mxint_exp_pkg;

    // Input element format is a signed mantissa with 3 fraction bits
    localparam int MAN_WIDTH = 4;

    // Shared block exponent is signed
    localparam int EXP_WIDTH = 8;

    // Rounded integer part n of x*log2(e) is signed
    localparam int N_WIDTH = 8;

    // Residual r = x - n*ln2 in signed fixed point
    localparam int R_WIDTH = 9;
    localparam int R_FRAC  = 7;

    // Mantissa after alignment to the residual grid, before subtraction
    localparam int ALIGN_WIDTH = 16;

    // log2(e) as Q1.6 with the value 92/64
    localparam logic signed [7:0] LOG2E_MAN  = 8'sd92;
    localparam int                LOG2E_FRAC = 6;

    // ln(2) as Q0.7 with the value 88/128
    localparam logic signed [7:0] LN2_MAN  = 8'sd88;
    localparam int                LN2_FRAC = 7;

    // Mantissa of e^r in unsigned Q3.7
    localparam int EXPM_WIDTH = 10;

    // One output lane from which downstream forms e^x = 2^n * mant
    typedef struct packed {
        logic [N_WIDTH-1:0]    n;
        logic [EXPM_WIDTH-1:0] mant;
    } exp_elem_t;

endpackage

// File: verilog/mxint_log2e_round.sv
`timescale 1ns/100ps

module mxint_log2e_round
    import mxint_exp_pkg::*;
#(
    parameter int BLOCK_SIZE = 4
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [BLOCK_SIZE-1:0][MAN_WIDTH-1:0] in_mant,
    input  logic [EXP_WIDTH-1:0]                 in_exp,
    input  logic                                in_valid,
    output logic                                in_ready,
    output logic [BLOCK_SIZE-1:0][N_WIDTH-1:0]   n_out,
    output logic                                n_valid,
    input  logic                                n_ready
);
    localparam int PROD_WIDTH = MAN_WIDTH + $bits(LOG2E_MAN);
    // Product carries the mantissa fraction bits plus the log2(e) fraction bits
    localparam int SHIFT_BIAS = (MAN_WIDTH - 1) + LOG2E_FRAC;
    localparam int N_MAX      = 2 ** (N_WIDTH - 1) - 1;
    localparam int N_MIN      = -(2 ** (N_WIDTH - 1));

    logic [BLOCK_SIZE-1:0][N_WIDTH-1:0] n_next;

    // floor(p * 2^(e - bias) + 1/2), saturated to the n range
    function automatic logic [N_WIDTH-1:0] round_sat(
        input logic signed [PROD_WIDTH-1:0] p,
        input logic signed [EXP_WIDTH-1:0]  e
    );
        int sh;
        int rs;
        int v;
        sh = int'(e) - SHIFT_BIAS;
        v  = int'(p);
        if (sh > N_WIDTH) begin
            // Every nonzero product overflows n this far up
            v = (p == '0) ? 0 : ((p < 0) ? N_MIN : N_MAX);
        end else if (sh >= 0) begin
            v = v <<< sh;
        end else begin
            rs = (-sh > PROD_WIDTH + 2) ? PROD_WIDTH + 2 : -sh;
            v  = (v + (1 <<< (rs - 1))) >>> rs;
        end
        if (v > N_MAX) begin
            v = N_MAX;
        end else if (v < N_MIN) begin
            v = N_MIN;
        end
        return N_WIDTH'(v);
    endfunction

    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_lane
        logic signed [PROD_WIDTH-1:0] p;
        assign p         = $signed(in_mant[i]) * LOG2E_MAN;
        assign n_next[i] = round_sat(p, in_exp);
    end

    assign in_ready = !n_valid || n_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            n_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            n_valid <= 1'b1;
        end else if (n_ready) begin
            n_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            n_out <= n_next;
        end
    end

endmodule

// File: verilog/mxint_range_reduction.sv
`timescale 1ns/100ps

module mxint_range_reduction
    import mxint_exp_pkg::*;
#(
    parameter int BLOCK_SIZE      = 4,
    parameter int MANT_FIFO_DEPTH = 2,
    parameter int N_FIFO_DEPTH    = 3
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [BLOCK_SIZE-1:0][MAN_WIDTH-1:0] in_mant,
    input  logic [EXP_WIDTH-1:0]                 in_exp,
    input  logic                                in_valid,
    output logic                                in_ready,
    output logic [BLOCK_SIZE-1:0][N_WIDTH-1:0]   n_out,
    output logic                                n_valid,
    input  logic                                n_ready,
    output logic [BLOCK_SIZE-1:0][R_WIDTH-1:0]   r_out,
    output logic                                r_valid,
    input  logic                                r_ready
);
    typedef struct packed {
        logic [BLOCK_SIZE-1:0][MAN_WIDTH-1:0] mant;
        logic [EXP_WIDTH-1:0]                 exp;
    } mx_block_t;

    mx_block_t                          in_blk;
    mx_block_t                          straight_blk;
    logic                               straight_valid;
    logic                               straight_ready;
    mx_block_t                          fifo_blk;
    logic                               fifo_valid;
    logic                               fifo_ready;
    logic [BLOCK_SIZE-1:0][N_WIDTH-1:0] round_n;
    logic                               round_valid;
    logic                               round_ready;
    logic [BLOCK_SIZE-1:0][N_WIDTH-1:0] join_n;
    logic                               join_n_valid;
    logic                               join_n_ready;

    assign in_blk = '{mant: in_mant, exp: in_exp};

    // The mantissas wait in the FIFO while n is being rounded
    stream_fork #(
        .DATA_WIDTH ($bits(mx_block_t)),
        .DEPTH      (MANT_FIFO_DEPTH)
    ) u_in_fork (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_data        (in_blk),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .straight_data  (straight_blk),
        .straight_valid (straight_valid),
        .straight_ready (straight_ready),
        .fifo_data      (fifo_blk),
        .fifo_valid     (fifo_valid),
        .fifo_ready     (fifo_ready)
    );

    mxint_log2e_round #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_round (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_mant  (straight_blk.mant),
        .in_exp   (straight_blk.exp),
        .in_valid (straight_valid),
        .in_ready (straight_ready),
        .n_out    (round_n),
        .n_valid  (round_valid),
        .n_ready  (round_ready)
    );

    stream_fork #(
        .DATA_WIDTH (BLOCK_SIZE * N_WIDTH),
        .DEPTH      (N_FIFO_DEPTH)
    ) u_n_fork (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_data        (round_n),
        .in_valid       (round_valid),
        .in_ready       (round_ready),
        .straight_data  (join_n),
        .straight_valid (join_n_valid),
        .straight_ready (join_n_ready),
        .fifo_data      (n_out),
        .fifo_valid     (n_valid),
        .fifo_ready     (n_ready)
    );

    range_residual #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_residual (
        .clk        (clk),
        .arst_n     (arst_n),
        .n_in       (join_n),
        .n_valid    (join_n_valid),
        .n_ready    (join_n_ready),
        .mant_in    (fifo_blk.mant),
        .exp_in     (fifo_blk.exp),
        .mant_valid (fifo_valid),
        .mant_ready (fifo_ready),
        .r_out      (r_out),
        .r_valid    (r_valid),
        .r_ready    (r_ready)
    );

endmodule

// File: verilog/range_residual.sv
`timescale 1ns/100ps

module range_residual
    import mxint_exp_pkg::*;
#(
    parameter int BLOCK_SIZE = 4
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [BLOCK_SIZE-1:0][N_WIDTH-1:0]   n_in,
    input  logic                                n_valid,
    output logic                                n_ready,
    input  logic [BLOCK_SIZE-1:0][MAN_WIDTH-1:0] mant_in,
    input  logic [EXP_WIDTH-1:0]                 exp_in,
    input  logic                                mant_valid,
    output logic                                mant_ready,
    output logic [BLOCK_SIZE-1:0][R_WIDTH-1:0]   r_out,
    output logic                                r_valid,
    input  logic                                r_ready
);
    // x * 2^R_FRAC = m * 2^(e + R_FRAC - mantissa fraction bits)
    localparam int ALIGN_BIAS = R_FRAC - (MAN_WIDTH - 1);
    localparam int A_MAX      = 2 ** (ALIGN_WIDTH - 1) - 1;
    localparam int A_MIN      = -(2 ** (ALIGN_WIDTH - 1));
    localparam int NL_WIDTH   = N_WIDTH + $bits(LN2_MAN);
    localparam int DIFF_WIDTH = ALIGN_WIDTH + 2;

    localparam logic signed [R_WIDTH-1:0] R_MAX = {1'b0, {(R_WIDTH - 1){1'b1}}};
    localparam logic signed [R_WIDTH-1:0] R_MIN = {1'b1, {(R_WIDTH - 1){1'b0}}};

    logic [BLOCK_SIZE-1:0][R_WIDTH-1:0] r_next;
    logic                              out_accept;
    logic                              fire;

    function automatic logic signed [ALIGN_WIDTH-1:0] align(
        input logic signed [MAN_WIDTH-1:0] m,
        input logic signed [EXP_WIDTH-1:0] e
    );
        int sh;
        int v;
        sh = int'(e) + ALIGN_BIAS;
        v  = int'(m);
        if (sh >= ALIGN_WIDTH) begin
            v = (m == '0) ? 0 : ((m < 0) ? A_MIN : A_MAX);
        end else if (sh >= 0) begin
            v = v <<< sh;
        end else begin
            // Past MAN_WIDTH the result is only the sign
            v = v >>> ((-sh > MAN_WIDTH) ? MAN_WIDTH : -sh);
        end
        if (v > A_MAX) begin
            v = A_MAX;
        end else if (v < A_MIN) begin
            v = A_MIN;
        end
        return ALIGN_WIDTH'(v);
    endfunction

    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_lane
        logic signed [ALIGN_WIDTH-1:0] a;
        logic signed [NL_WIDTH-1:0]    nl;
        logic signed [DIFF_WIDTH-1:0]  diff;
        assign a         = align(mant_in[i], exp_in);
        assign nl        = $signed(n_in[i]) * LN2_MAN;
        assign diff      = a - nl;
        assign r_next[i] = (diff > R_MAX) ? R_MAX :
                           (diff < R_MIN) ? R_MIN : diff[R_WIDTH-1:0];
    end

    // Join of n with the buffered mantissa block
    assign out_accept = !r_valid || r_ready;
    assign fire       = n_valid && mant_valid && out_accept;
    assign n_ready    = mant_valid && out_accept;
    assign mant_ready = n_valid && out_accept;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_valid <= 1'b0;
        end else if (fire) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            r_out <= r_next;
        end
    end

endmodule

// File: verilog/stream_fork.sv
`timescale 1ns/100ps

module stream_fork #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] straight_data,
    output logic                  straight_valid,
    input  logic                  straight_ready,
    output logic [DATA_WIDTH-1:0] fifo_data,
    output logic                  fifo_valid,
    input  logic                  fifo_ready
);
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [CNT_WIDTH-1:0]  count;
    logic                  full;
    logic                  push;
    logic                  pop;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_WIDTH'(DEPTH));

    // The item leaves on both branches in the same cycle or not at all
    assign in_ready       = straight_ready && !full;
    assign straight_valid = in_valid && !full;
    assign straight_data  = in_data;
    assign push           = in_valid && in_ready;

    assign fifo_valid = (count != '0);
    assign fifo_data  = mem[rd_ptr];
    assign pop        = fifo_valid && fifo_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_WIDTH'(push) - CNT_WIDTH'(pop);
        end
    end

endmodule
